// ==== agc_params.svh ====
`ifndef AGC_PARAMS_SVH
`define AGC_PARAMS_SVH

// Bus and gain word widths
`define AGC_ADR_W               8
`define AGC_DAT_W               32
`define AGC_SCALE_W             17
`define AGC_OFFSET_W            16

// Loop constants
`define AGC_START_SCALE         1500
`define AGC_START_OFFSET        0
`define AGC_SCALE_MIN           300
`define AGC_SCALE_MAX           130000
`define AGC_OFFSET_LIM          1000
`define AGC_TARGET_RMS_SQ       16
`define AGC_RMS_ERR             0
`define AGC_OFFSET_ERR          5
`define AGC_SQ_SHIFT            13
`define AGC_START_SCALE_DELTA   30
`define AGC_START_OFFSET_DELTA  25
`define AGC_BOOT_CYCLES         31

// Core register map
`define AGC_CORE_CTRL           8'h00
`define AGC_CORE_SCALE          8'h10
`define AGC_CORE_OFFSET         8'h14

// Command words for the core control address
`define AGC_CMD_RESET           32'h0000_0004
`define AGC_CMD_START           32'h0000_0001
`define AGC_CMD_LOAD            32'h0000_0300
`define AGC_CMD_APPLY           32'h0000_0400

// Host register map
`define AGC_REG_ENABLE          8'h18
`define AGC_REG_SCALE_DELTA     8'h40
`define AGC_REG_OFFSET_DELTA    8'h44

`endif

// ==== agc_bus_pkg.sv ====
`include "agc_params.svh"

package agc_bus_pkg;

    // Wishbone address and data words
    typedef logic [`AGC_ADR_W-1:0] wb_adr_t;
    typedef logic [`AGC_DAT_W-1:0] wb_dat_t;

    // Master engine, one classic cycle at a time
    typedef enum logic {
        IDLE,
        BUSY
    } bus_state_t;

endpackage

// ==== agc_loop_pkg.sv ====
`include "agc_params.svh"

package agc_loop_pkg;

    typedef logic        [`AGC_SCALE_W-1:0]  scale_t;
    typedef logic signed [`AGC_OFFSET_W-1:0] offset_t;

    // Statistic word index, words 0 to 5
    typedef logic [2:0] stat_idx_t;

    // Round sequencer
    typedef enum logic [3:0] {
        BOOT,
        RESET_CORE,
        START,
        POLL,
        READ_STATS,
        CALC,
        WRITE_SCALE,
        WRITE_OFFSET,
        LOAD,
        APPLY
    } loop_state_t;

endpackage

// ==== agc_bus_master.sv ====
`timescale 1ns/1ps

module agc_bus_master import agc_bus_pkg::*; (
    input  logic       aclk,
    input  logic       wb_rst_i,
    input  logic       cmd_valid_i,
    input  logic       cmd_we_i,
    input  wb_adr_t    cmd_adr_i,
    input  wb_dat_t    cmd_dat_i,
    output logic       cmd_ready_o,
    output logic       rsp_done_o,
    output wb_dat_t    rsp_dat_o,
    output logic       core_cyc_o,
    output logic       core_stb_o,
    output logic       core_we_o,
    output wb_adr_t    core_adr_o,
    output wb_dat_t    core_dat_o,
    output logic [3:0] core_sel_o,
    input  logic       core_ack_i,
    input  wb_dat_t    core_dat_i
);

    bus_state_t state;

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state      <= IDLE;
            core_cyc_o <= 1'b0;
            core_we_o  <= 1'b0;
            rsp_done_o <= 1'b0;
        end else begin
            rsp_done_o <= 1'b0;
            case (state)
                IDLE: if (cmd_valid_i) begin
                    state      <= BUSY;
                    core_cyc_o <= 1'b1;
                    core_we_o  <= cmd_we_i;
                end
                BUSY: if (core_ack_i) begin   // Single cycle ends on ack
                    state      <= IDLE;
                    core_cyc_o <= 1'b0;
                    core_we_o  <= 1'b0;
                    rsp_done_o <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address, write data and read data
    always_ff @(posedge aclk) begin
        if (state == IDLE && cmd_valid_i) begin
            core_adr_o <= cmd_adr_i;
            core_dat_o <= cmd_dat_i;
        end
        if (state == BUSY && core_ack_i)
            rsp_dat_o <= core_dat_i;
    end

    assign cmd_ready_o = (state == IDLE);
    assign core_stb_o  = core_cyc_o;
    assign core_sel_o  = {4{core_cyc_o}};   // Full words only

endmodule

// ==== agc_loop_sequencer.sv ====
`timescale 1ns/1ps
`include "agc_params.svh"

module agc_loop_sequencer import agc_bus_pkg::*, agc_loop_pkg::*; (
    input  logic    aclk,
    input  logic    wb_rst_i,
    input  logic    agc_en_i,
    // Bus engine
    output logic    cmd_valid_o,
    output logic    cmd_we_o,
    output wb_adr_t cmd_adr_o,
    output wb_dat_t cmd_dat_o,
    input  logic    cmd_ready_i,
    input  logic    rsp_done_i,
    input  wb_dat_t rsp_dat_i,
    // Gain calculator
    output logic    stats_valid_o,
    output wb_dat_t stat_status_o,
    output wb_dat_t stat_sq_o,
    output wb_dat_t stat_above_o,
    output wb_dat_t stat_below_o,
    output scale_t  stat_scale_o,
    output offset_t stat_offset_o,
    input  logic    gain_valid_i,
    input  scale_t  new_scale_i,
    input  offset_t new_offset_i,
    // Applied gains for read-back
    output scale_t  mirror_scale_o,
    output offset_t mirror_offset_o,
    output logic    mirror_en_o
);

    localparam int BOOT_W = $clog2(`AGC_BOOT_CYCLES);

    loop_state_t       state;
    stat_idx_t         stat_idx;
    logic [BOOT_W-1:0] boot_cnt;
    logic              waiting;    // Bus command or calc request outstanding
    scale_t            scale_r;    // Next values to commit
    offset_t           offset_r;

    // Command decode ////////////////////////
    always_comb begin
        cmd_we_o  = 1'b1;
        cmd_adr_o = `AGC_CORE_CTRL;
        cmd_dat_o = '0;
        case (state)
            RESET_CORE:   cmd_dat_o = `AGC_CMD_RESET;
            START:        cmd_dat_o = `AGC_CMD_START;
            POLL:         cmd_we_o  = 1'b0;     // Status word at 0x00
            READ_STATS: begin
                cmd_we_o  = 1'b0;
                cmd_adr_o = wb_adr_t'({stat_idx, 2'b00});
            end
            WRITE_SCALE: begin
                cmd_adr_o = `AGC_CORE_SCALE;
                cmd_dat_o = wb_dat_t'(scale_r);
            end
            WRITE_OFFSET: begin
                cmd_adr_o = `AGC_CORE_OFFSET;
                cmd_dat_o = wb_dat_t'(offset_r);  // Sign extended
            end
            LOAD:         cmd_dat_o = `AGC_CMD_LOAD;
            APPLY:        cmd_dat_o = `AGC_CMD_APPLY;
            default:      cmd_dat_o = '0;
        endcase
    end

    // Round FSM /////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state           <= BOOT;
            boot_cnt        <= BOOT_W'(`AGC_BOOT_CYCLES - 1);
            stat_idx        <= '0;
            waiting         <= 1'b0;
            cmd_valid_o     <= 1'b0;
            stats_valid_o   <= 1'b0;
            scale_r         <= scale_t'(`AGC_START_SCALE);
            offset_r        <= offset_t'(`AGC_START_OFFSET);
            stat_status_o   <= '0;
            stat_sq_o       <= '0;
            stat_above_o    <= '0;
            stat_below_o    <= '0;
            mirror_scale_o  <= '0;
            mirror_offset_o <= '0;
            mirror_en_o     <= 1'b0;
        end else begin
            stats_valid_o <= 1'b0;
            if (cmd_valid_o && cmd_ready_i)
                cmd_valid_o <= 1'b0;

            case (state)
                BOOT: begin
                    if (boot_cnt != '0)
                        boot_cnt <= boot_cnt - 1'b1;
                    else
                        state <= WRITE_SCALE;   // Commit the start values first
                end
                CALC: begin
                    if (!waiting) begin
                        stats_valid_o <= 1'b1;
                        waiting       <= 1'b1;
                    end else if (gain_valid_i) begin
                        scale_r  <= new_scale_i;
                        offset_r <= new_offset_i;
                        waiting  <= 1'b0;
                        state    <= WRITE_SCALE;
                    end
                end
                default: begin
                    if (!waiting) begin
                        cmd_valid_o <= 1'b1;
                        waiting     <= 1'b1;
                    end else if (rsp_done_i) begin
                        waiting <= 1'b0;
                        case (state)
                            RESET_CORE: state <= START;
                            START:      state <= POLL;
                            POLL: if (rsp_dat_i[1]) begin   // Sample period done
                                state    <= READ_STATS;
                                stat_idx <= '0;
                            end
                            READ_STATS: begin
                                case (stat_idx)
                                    3'd0:    stat_status_o <= rsp_dat_i;
                                    3'd1:    stat_sq_o     <= rsp_dat_i;
                                    3'd2:    stat_above_o  <= rsp_dat_i;
                                    3'd3:    stat_below_o  <= rsp_dat_i;
                                    3'd4:    stat_scale_o  <= scale_t'(rsp_dat_i);
                                    default: stat_offset_o <= offset_t'(rsp_dat_i);
                                endcase
                                if (stat_idx == 3'd5)
                                    state <= CALC;
                                else
                                    stat_idx <= stat_idx + 1'b1;
                            end
                            WRITE_SCALE:  state <= WRITE_OFFSET;
                            WRITE_OFFSET: state <= LOAD;
                            LOAD:         state <= APPLY;
                            APPLY: begin    // Round complete
                                mirror_scale_o  <= scale_r;
                                mirror_offset_o <= offset_r;
                                mirror_en_o     <= agc_en_i;
                                state           <= RESET_CORE;
                            end
                            default: state <= BOOT;
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

// ==== agc_gain_calc.sv ====
`timescale 1ns/1ps
`include "agc_params.svh"

module agc_gain_calc import agc_bus_pkg::*, agc_loop_pkg::*; (
    input  logic    aclk,
    input  logic    wb_rst_i,
    input  logic    stats_valid_i,
    input  wb_dat_t stat_status_i,
    input  wb_dat_t stat_sq_i,
    input  wb_dat_t stat_above_i,
    input  wb_dat_t stat_below_i,
    input  scale_t  stat_scale_i,
    input  offset_t stat_offset_i,
    input  scale_t  scale_delta_i,
    input  offset_t offset_delta_i,
    output logic    gain_valid_o,
    output scale_t  new_scale_o,
    output offset_t new_offset_o
);

    wb_dat_t sq_adj;
    scale_t  next_scale;
    offset_t next_offset;

    assign sq_adj = stat_sq_i >> `AGC_SQ_SHIFT;   // Square on the target time scale

    always_comb begin
        next_scale  = stat_scale_i;
        next_offset = stat_offset_i;
        if (stat_status_i[1]) begin     // Only a finished sample period counts
            // Scale toward the target RMS
            if (sq_adj > `AGC_TARGET_RMS_SQ + `AGC_RMS_ERR) begin
                if (stat_scale_i > `AGC_SCALE_MIN)
                    next_scale = stat_scale_i - scale_delta_i;
            end else if (sq_adj < `AGC_TARGET_RMS_SQ - `AGC_RMS_ERR) begin
                if (stat_scale_i < `AGC_SCALE_MAX)
                    next_scale = stat_scale_i + scale_delta_i;
            end
            // Offset balances the above and below counts
            if (stat_above_i > stat_below_i + `AGC_OFFSET_ERR) begin
                if (stat_offset_i > -`AGC_OFFSET_LIM)
                    next_offset = stat_offset_i - offset_delta_i;
            end else if (stat_below_i > stat_above_i + `AGC_OFFSET_ERR) begin
                if (stat_offset_i < `AGC_OFFSET_LIM)
                    next_offset = stat_offset_i + offset_delta_i;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i)
            gain_valid_o <= 1'b0;
        else
            gain_valid_o <= stats_valid_i;
    end

    always_ff @(posedge aclk) begin
        if (stats_valid_i) begin
            new_scale_o  <= next_scale;
            new_offset_o <= next_offset;
        end
    end

endmodule

// ==== agc_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "agc_params.svh"

module agc_ctrl_regs import agc_bus_pkg::*, agc_loop_pkg::*; (
    input  logic       aclk,
    input  logic       wb_rst_i,
    input  logic       host_cyc_i,
    input  logic       host_stb_i,
    input  logic       host_we_i,
    input  wb_adr_t    host_adr_i,
    input  wb_dat_t    host_dat_i,
    input  logic [3:0] host_sel_i,
    output logic       host_ack_o,
    output wb_dat_t    host_dat_o,
    input  wb_dat_t    mirror_status_i,
    input  wb_dat_t    mirror_sq_i,
    input  wb_dat_t    mirror_above_i,
    input  wb_dat_t    mirror_below_i,
    input  scale_t     mirror_scale_i,
    input  offset_t    mirror_offset_i,
    input  logic       mirror_en_i,
    output scale_t     scale_delta_o,
    output offset_t    offset_delta_o,
    output logic       agc_en_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_ACK
    } reg_state_t;

    reg_state_t state;
    wb_dat_t    wr_scale;
    wb_dat_t    wr_offset;
    wb_dat_t    rd_word;

    // Byte lanes not selected keep the old value
    function automatic wb_dat_t lane_merge(wb_dat_t old_w, wb_dat_t new_w, logic [3:0] sel);
        wb_dat_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b])
                w[8*b +: 8] = new_w[8*b +: 8];
        end
        return w;
    endfunction

    assign wr_scale  = lane_merge(wb_dat_t'(scale_delta_o), host_dat_i, host_sel_i);
    assign wr_offset = lane_merge(wb_dat_t'(offset_delta_o), host_dat_i, host_sel_i);

    // Read map //////////////////////////////
    always_comb begin
        rd_word = '0;
        if (host_adr_i[6]) begin    // Loop steps
            case (host_adr_i[5:2])
                4'd0:    rd_word = wb_dat_t'(scale_delta_o);
                4'd1:    rd_word = wb_dat_t'(offset_delta_o);
                default: rd_word = '0;
            endcase
        end else begin              // Core mirror words
            case (host_adr_i[5:2])
                4'd0:    rd_word = mirror_status_i;
                4'd1:    rd_word = mirror_sq_i;
                4'd2:    rd_word = mirror_above_i;
                4'd3:    rd_word = mirror_below_i;
                4'd4:    rd_word = wb_dat_t'(mirror_scale_i);
                4'd5:    rd_word = wb_dat_t'(mirror_offset_i);
                4'd6:    rd_word = wb_dat_t'(mirror_en_i);
                default: rd_word = '0;
            endcase
        end
    end

    // Slave FSM /////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state          <= ST_IDLE;
            scale_delta_o  <= scale_t'(`AGC_START_SCALE_DELTA);
            offset_delta_o <= offset_t'(`AGC_START_OFFSET_DELTA);
            agc_en_o       <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: if (host_cyc_i && host_stb_i)
                    state <= host_we_i ? ST_WRITE : ST_READ;
                ST_WRITE: begin
                    state <= ST_ACK;
                    case (host_adr_i)
                        `AGC_REG_ENABLE:       if (host_sel_i[0]) agc_en_o <= host_dat_i[0];
                        `AGC_REG_SCALE_DELTA:  scale_delta_o  <= scale_t'(wr_scale);
                        `AGC_REG_OFFSET_DELTA: offset_delta_o <= offset_t'(wr_offset);
                        default: ;              // Acked, no effect
                    endcase
                end
                ST_READ: state <= ST_ACK;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == ST_READ)
            host_dat_o <= rd_word;      // Held through ack
    end

    assign host_ack_o = (state == ST_ACK);

endmodule

// ==== agc_loop_top.sv ====
`timescale 1ns/1ps

module agc_loop_top import agc_bus_pkg::*, agc_loop_pkg::*; (
    input  logic       aclk,
    input  logic       wb_rst_i,
    // Host slave port
    input  logic       host_cyc_i,
    input  logic       host_stb_i,
    input  logic       host_we_i,
    input  wb_adr_t    host_adr_i,
    input  wb_dat_t    host_dat_i,
    input  logic [3:0] host_sel_i,
    output logic       host_ack_o,
    output wb_dat_t    host_dat_o,
    // AGC core master port
    output logic       core_cyc_o,
    output logic       core_stb_o,
    output logic       core_we_o,
    output wb_adr_t    core_adr_o,
    output wb_dat_t    core_dat_o,
    output logic [3:0] core_sel_o,
    input  logic       core_ack_i,
    input  wb_dat_t    core_dat_i,
    output logic       agc_en_o
);

    logic    cmd_valid, cmd_ready, cmd_we, rsp_done;
    wb_adr_t cmd_adr;
    wb_dat_t cmd_dat, rsp_dat;
    logic    stats_valid, gain_valid, mirror_en;
    wb_dat_t stat_status, stat_sq, stat_above, stat_below;
    scale_t  stat_scale, new_scale, scale_delta, mirror_scale;
    offset_t stat_offset, new_offset, offset_delta, mirror_offset;

    agc_ctrl_regs u_regs (
        .aclk(aclk), .wb_rst_i(wb_rst_i),
        .host_cyc_i(host_cyc_i), .host_stb_i(host_stb_i), .host_we_i(host_we_i),
        .host_adr_i(host_adr_i), .host_dat_i(host_dat_i), .host_sel_i(host_sel_i),
        .host_ack_o(host_ack_o), .host_dat_o(host_dat_o),
        .mirror_status_i(stat_status), .mirror_sq_i(stat_sq),
        .mirror_above_i(stat_above), .mirror_below_i(stat_below),
        .mirror_scale_i(mirror_scale), .mirror_offset_i(mirror_offset),
        .mirror_en_i(mirror_en),
        .scale_delta_o(scale_delta), .offset_delta_o(offset_delta), .agc_en_o(agc_en_o)
    );

    agc_loop_sequencer u_seq (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .agc_en_i(agc_en_o),
        .cmd_valid_o(cmd_valid), .cmd_we_o(cmd_we), .cmd_adr_o(cmd_adr),
        .cmd_dat_o(cmd_dat), .cmd_ready_i(cmd_ready),
        .rsp_done_i(rsp_done), .rsp_dat_i(rsp_dat),
        .stats_valid_o(stats_valid), .stat_status_o(stat_status), .stat_sq_o(stat_sq),
        .stat_above_o(stat_above), .stat_below_o(stat_below),
        .stat_scale_o(stat_scale), .stat_offset_o(stat_offset),
        .gain_valid_i(gain_valid), .new_scale_i(new_scale), .new_offset_i(new_offset),
        .mirror_scale_o(mirror_scale), .mirror_offset_o(mirror_offset),
        .mirror_en_o(mirror_en)
    );

    agc_gain_calc u_calc (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .stats_valid_i(stats_valid),
        .stat_status_i(stat_status), .stat_sq_i(stat_sq),
        .stat_above_i(stat_above), .stat_below_i(stat_below),
        .stat_scale_i(stat_scale), .stat_offset_i(stat_offset),
        .scale_delta_i(scale_delta), .offset_delta_i(offset_delta),
        .gain_valid_o(gain_valid), .new_scale_o(new_scale), .new_offset_o(new_offset)
    );

    agc_bus_master u_bus (
        .aclk(aclk), .wb_rst_i(wb_rst_i),
        .cmd_valid_i(cmd_valid), .cmd_we_i(cmd_we), .cmd_adr_i(cmd_adr),
        .cmd_dat_i(cmd_dat), .cmd_ready_o(cmd_ready),
        .rsp_done_o(rsp_done), .rsp_dat_o(rsp_dat),
        .core_cyc_o(core_cyc_o), .core_stb_o(core_stb_o), .core_we_o(core_we_o),
        .core_adr_o(core_adr_o), .core_dat_o(core_dat_o), .core_sel_o(core_sel_o),
        .core_ack_i(core_ack_i), .core_dat_i(core_dat_i)
    );

endmodule

// ==== tb_agc_loop.sv ====
`timescale 1ns/1ps
`include "agc_params.svh"

module tb_agc_loop;

    logic        aclk;
    logic        wb_rst_i;
    logic        host_cyc_i, host_stb_i, host_we_i;
    logic [7:0]  host_adr_i;
    logic [31:0] host_dat_i;
    logic [3:0]  host_sel_i;
    logic        host_ack_o;
    logic [31:0] host_dat_o;
    logic        core_cyc_o, core_stb_o, core_we_o;
    logic [7:0]  core_adr_o;
    logic [31:0] core_dat_o;
    logic [3:0]  core_sel_o;
    logic        core_ack_i;
    logic [31:0] core_dat_i;
    logic        agc_en_o;

    int errors = 0;
    int checks = 0;
    int n_rounds = 0;
    bit tests_loaded = 1'b0;

    // Rounds from the data file, host steps indexed by r_host
    int r_polls[$], r_sq[$], r_above[$], r_below[$], r_scale[$], r_offset[$], r_host[$];
    int h_sstep[$], h_ostep[$], h_en[$];

    // Core model state
    bit          core_hold = 1'b0;      // Set on apply, freezes the core between rounds
    int          cur_polls = 0;
    int          poll_cnt  = 0;
    logic [31:0] cur_sq = '0, cur_above = '0, cur_below = '0;
    logic [31:0] core_scale_w = '0, core_offset_w = '0;
    bit          log_we[$];
    logic [7:0]  log_adr[$];
    logic [31:0] log_dat[$];

    agc_loop_top dut (.*);

    initial aclk = 1'b0;
    always #20 aclk = ~aclk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic host_access(input bit we, input logic [7:0] adr,
                               input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        @(posedge aclk);
        #2;
        host_cyc_i = 1'b1;
        host_stb_i = 1'b1;
        host_we_i  = we;
        host_adr_i = adr;
        host_dat_i = wdat;
        host_sel_i = 4'hf;
        n = 0;
        do begin
            @(posedge aclk);
            #1;
            n++;
        end while (!host_ack_o);
        rdat = host_dat_o;
        check_value("host_ack_o delay", 32'(n), 32'd2);
        #1;
        host_cyc_i = 1'b0;
        host_stb_i = 1'b0;
        host_we_i  = 1'b0;
    endtask

    task automatic host_read(input logic [7:0] adr, input logic [31:0] exp, input string name);
        logic [31:0] d;
        host_access(1'b0, adr, 32'h0, d);
        check_value({name, " host_dat_o"}, d, exp);
    endtask

    task automatic host_write(input logic [7:0] adr, input logic [31:0] wdat);
        logic [31:0] d;
        host_access(1'b1, adr, wdat, d);
    endtask

    // Pops one logged core access and compares it
    task automatic expect_access(input string what, input bit we, input logic [7:0] adr,
                                 input logic [31:0] dat, input bit cmp_dat);
        bit          w;
        logic [7:0]  a;
        logic [31:0] d;
        if (log_we.size() == 0) begin
            $display("Error: %s expected, but no further core access was logged", what);
            errors++;
        end else begin
            w = log_we.pop_front();
            a = log_adr.pop_front();
            d = log_dat.pop_front();
            check_value({what, " core_we_o"}, 32'(w), 32'(we));
            check_value({what, " core_adr_o"}, 32'(a), 32'(adr));
            if (cmp_dat)
                check_value({what, " core_dat_o"}, d, dat);
        end
    endtask

    // Apply seen and the next round's first cycle raised
    task automatic wait_round_end();
        do begin
            @(posedge aclk);
            #1;
        end while (!(core_hold && core_cyc_o));
    endtask

    task automatic check_commit(input int scale, input int offset);
        expect_access("scale write", 1'b1, `AGC_CORE_SCALE, 32'(scale), 1'b1);
        expect_access("offset write", 1'b1, `AGC_CORE_OFFSET, 32'(offset), 1'b1);
        expect_access("load command", 1'b1, `AGC_CORE_CTRL, `AGC_CMD_LOAD, 1'b1);
        expect_access("apply command", 1'b1, `AGC_CORE_CTRL, `AGC_CMD_APPLY, 1'b1);
        check_value("extra core accesses", 32'(log_we.size()), 32'd0);
    endtask

    ////////////////////////////////////////
    // AGC core model
    initial begin
        int          waits;
        logic [31:0] rd;
        void'($urandom(32'hdc5b_4b29));
        core_ack_i = 1'b0;
        core_dat_i = '0;
        forever begin
            @(posedge aclk);
            #1;
            if (core_cyc_o && !core_hold) begin
                waits = $urandom_range(3, 0);
                #1;
                repeat (waits) begin
                    @(posedge aclk);
                    #2;
                end
                check_value("core_stb_o", 32'(core_stb_o), 32'h1);
                check_value("core_sel_o", 32'(core_sel_o), 32'hf);
                rd = '0;
                if (core_we_o) begin
                    rd = core_dat_o;
                    if (core_adr_o == `AGC_CORE_SCALE)
                        core_scale_w = core_dat_o;
                    if (core_adr_o == `AGC_CORE_OFFSET)
                        core_offset_w = core_dat_o;
                    if (core_adr_o == `AGC_CORE_CTRL && core_dat_o == `AGC_CMD_START)
                        poll_cnt = 0;
                    if (core_adr_o == `AGC_CORE_CTRL && core_dat_o == `AGC_CMD_APPLY)
                        core_hold = 1'b1;
                end else begin
                    case (core_adr_o)
                        8'h00: begin
                            rd = (poll_cnt < cur_polls) ? 32'h0 : 32'h2;  // Done is bit 1
                            poll_cnt++;
                        end
                        8'h04:   rd = cur_sq;
                        8'h08:   rd = cur_above;
                        8'h0c:   rd = cur_below;
                        8'h10:   rd = core_scale_w;
                        8'h14:   rd = core_offset_w;
                        default: rd = '0;
                    endcase
                end
                log_we.push_back(core_we_o);
                log_adr.push_back(core_adr_o);
                log_dat.push_back(rd);
                core_ack_i = 1'b1;
                core_dat_i = rd;
                @(posedge aclk);
                #2;
                core_ack_i = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence
    initial begin
        int    fd, a, b, c, d, e, f, host_idx, en_exp;
        string line;
        host_cyc_i = 1'b0;
        host_stb_i = 1'b0;
        host_we_i  = 1'b0;
        host_adr_i = '0;
        host_dat_i = '0;
        host_sel_i = '0;
        wb_rst_i   = 1'b1;
        host_idx   = -1;
        en_exp     = 1;

        fd = $fopen("agc_loop_tests.txt", "r");
        if (fd == 0) begin
            $display("Error: the test file agc_loop_tests.txt could not be opened");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line.getc(0) == "#") continue;
                if (line.getc(0) == "H" && $sscanf(line, "H %d %d %d", a, b, c) == 3) begin
                    h_sstep.push_back(a);
                    h_ostep.push_back(b);
                    h_en.push_back(c);
                    host_idx = h_en.size() - 1;
                end else if ($sscanf(line, "R %d %d %d %d %d %d", a, b, c, d, e, f) == 6) begin
                    r_polls.push_back(a);
                    r_sq.push_back(b);
                    r_above.push_back(c);
                    r_below.push_back(d);
                    r_scale.push_back(e);
                    r_offset.push_back(f);
                    r_host.push_back(host_idx);
                    host_idx = -1;
                end
            end
            $fclose(fd);
            n_rounds = r_polls.size();
            tests_loaded = 1'b1;

            repeat (3) @(posedge aclk);
            #2;
            wb_rst_i = 1'b0;

            // Boot commit of the start values
            wait_round_end();
            check_commit(`AGC_START_SCALE, `AGC_START_OFFSET);
            host_read(8'h10, 32'(`AGC_START_SCALE), "boot mirror scale");
            host_read(8'h14, 32'(`AGC_START_OFFSET), "boot mirror offset");
            host_read(8'h18, 32'd1, "boot mirror enable");
            host_read(`AGC_REG_SCALE_DELTA, 32'(`AGC_START_SCALE_DELTA), "scale step");
            host_read(`AGC_REG_OFFSET_DELTA, 32'(`AGC_START_OFFSET_DELTA), "offset step");

            for (int r = 0; r < n_rounds; r++) begin
                if (r_host[r] >= 0) begin
                    host_idx = r_host[r];
                    host_write(`AGC_REG_SCALE_DELTA, 32'(h_sstep[host_idx]));
                    host_write(`AGC_REG_OFFSET_DELTA, 32'(h_ostep[host_idx]));
                    host_write(`AGC_REG_ENABLE, 32'(h_en[host_idx]));
                    en_exp = h_en[host_idx];
                    check_value("agc_en_o", 32'(agc_en_o), 32'(en_exp));
                    host_read(`AGC_REG_SCALE_DELTA, 32'(h_sstep[host_idx]), "scale step");
                    host_read(`AGC_REG_OFFSET_DELTA, 32'(h_ostep[host_idx]), "offset step");
                end
                cur_polls = r_polls[r];
                cur_sq    = 32'(r_sq[r]);
                cur_above = 32'(r_above[r]);
                cur_below = 32'(r_below[r]);
                @(posedge aclk);
                #2;
                core_hold = 1'b0;       // Release the core for this round
                wait_round_end();

                expect_access("reset command", 1'b1, `AGC_CORE_CTRL, `AGC_CMD_RESET, 1'b1);
                expect_access("start command", 1'b1, `AGC_CORE_CTRL, `AGC_CMD_START, 1'b1);
                for (int p = 0; p <= r_polls[r]; p++)
                    expect_access("status poll", 1'b0, 8'h00, 32'h0, 1'b0);
                for (int s = 0; s < 6; s++)
                    expect_access("statistic read", 1'b0, 8'(s * 4), 32'h0, 1'b0);
                check_commit(r_scale[r], r_offset[r]);

                // Read-back after apply
                host_read(8'h00, 32'h2, "mirror status");
                host_read(8'h04, cur_sq, "mirror square");
                host_read(8'h08, cur_above, "mirror above");
                host_read(8'h0c, cur_below, "mirror below");
                host_read(8'h10, 32'(r_scale[r]), "mirror scale");
                host_read(8'h14, 32'(r_offset[r]), "mirror offset");
                host_read(8'h18, 32'(en_exp), "mirror enable");
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog sized from the number of rounds
    initial begin
        wait (tests_loaded);
        repeat (n_rounds * 400 + 200) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d clock cycles",
                 n_rounds * 400 + 200);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== agc_loop_tests.txt ====
# R polls square above below expected_scale expected_offset (decimal)
# H scale_step offset_step enable, written by the host before the next round
R 0 0 10 10 1530 0
R 2 131072 100 0 1530 -25
R 1 200000 0 6 1500 0
R 3 139263 5 0 1500 0
H 1300 600 1
R 0 1000000 0 50 200 600
R 1 1000000 0 50 200 1200
R 2 1000000 0 50 200 1200
H 65000 1500 0
R 0 0 50 0 65200 -300
R 3 0 50 0 130200 -1800
R 1 0 50 0 130200 -1800
H 30 25 1
R 2 300000 3 9 130170 -1775

// ==== agc_loop_top.f ====
+incdir+.
agc_bus_pkg.sv
agc_loop_pkg.sv
agc_bus_master.sv
agc_loop_sequencer.sv
agc_gain_calc.sv
agc_ctrl_regs.sv
agc_loop_top.sv
tb_agc_loop.sv

// ==== Makefile ====
TOP   = tb_agc_loop
FLIST = agc_loop_top.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Done: errors found" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
